//--- source/core_pkg.sv
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  localparam word_t reset_pc = 32'h0000_0000;

  // ADDI x0, x0, 0
  localparam word_t nop_instruction = 32'h0000_0013;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OpLoad  = 7'b000_0011,
    OpImm   = 7'b001_0011,
    OpStore = 7'b010_0011,
    OpReg   = 7'b011_0011,
    OpLui   = 7'b011_0111
  } opcode_t;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluSltu,
    AluSll,
    AluSrl,
    AluSra,
    AluPassB
  } alu_op_t;

  // Operand source in execute
  typedef enum logic [1:0] {
    FwdNone,
    FwdMem,
    FwdWb
  } forward_t;

endpackage

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  core_pkg::word_t     wr_data
);
  import core_pkg::*;

  // x0 has no storage
  word_t regs [1:2**reg_addr_width-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write is visible to decode
  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wr_en && wr_addr == addr) begin
      value = wr_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // Decode drops the write enable for rd x0
  a_no_x0_write: assert property (
    @(posedge clock) disable iff (reset) wr_en |-> wr_addr != '0
  );

endmodule

//--- source/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode (
  input  logic                clock,
  input  logic                reset,
  output core_pkg::word_t     inst_addr,
  input  core_pkg::word_t     inst,
  input  logic                mem_busy,
  input  logic                load_use_stall,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  output core_pkg::reg_addr_t id_rd,
  output core_pkg::word_t     id_imm,
  output core_pkg::alu_op_t   id_alu_op,
  output logic                id_use_imm,
  output logic                id_reg_we,
  output logic                id_load,
  output logic                id_store
);
  import core_pkg::*;

  word_t      pc;
  word_t      if_id_inst;
  logic       fetch_enable;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       writes_rd;

  assign fetch_enable = !mem_busy && !load_use_stall;

  // PC and IF/ID
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
      if_id_inst <= nop_instruction;
    end else if (fetch_enable) begin
      pc <= pc + 32'd4;
      if_id_inst <= inst;
    end
  end

  assign inst_addr = pc;

  assign opcode   = opcode_t'(if_id_inst[6:0]);
  assign funct3   = if_id_inst[14:12];
  assign rs1_addr = if_id_inst[19:15];
  assign rs2_addr = if_id_inst[24:20];
  assign id_rd    = if_id_inst[11:7];

  function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? AluSub : AluAdd;
      3'b001:  op = AluSll;
      3'b010:  op = AluSlt;
      3'b011:  op = AluSltu;
      3'b100:  op = AluXor;
      3'b101:  op = alt ? AluSra : AluSrl;
      3'b110:  op = AluOr;
      default: op = AluAnd;
    endcase
    return op;
  endfunction

  always_comb begin
    id_imm = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
    id_alu_op = AluAdd;
    id_use_imm = 1'b1;
    writes_rd = 1'b0;
    id_load = 1'b0;
    id_store = 1'b0;
    case (opcode)
      OpReg: begin
        id_alu_op = funct_to_alu(funct3, if_id_inst[30]);
        id_use_imm = 1'b0;
        writes_rd = 1'b1;
      end
      OpImm: begin
        // Only SRAI looks at bit 30
        id_alu_op = funct_to_alu(funct3, funct3 == 3'b101 && if_id_inst[30]);
        writes_rd = 1'b1;
      end
      OpLoad: begin
        writes_rd = 1'b1;
        id_load = 1'b1;
      end
      OpStore: begin
        id_imm = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
        id_store = 1'b1;
      end
      OpLui: begin
        id_imm = {if_id_inst[31:12], 12'b0};
        id_alu_op = AluPassB;
        writes_rd = 1'b1;
      end
      default: begin
        // Unknown opcode becomes a bubble
        writes_rd = 1'b0;
      end
    endcase
  end

  assign id_reg_we = writes_rd && id_rd != '0;

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                mem_busy,
  input  core_pkg::reg_addr_t id_rd,
  input  core_pkg::word_t     id_imm,
  input  core_pkg::alu_op_t   id_alu_op,
  input  logic                id_use_imm,
  input  logic                id_reg_we,
  input  logic                id_load,
  input  logic                id_store,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  input  core_pkg::reg_addr_t mem_rd,
  input  logic                mem_reg_we,
  input  core_pkg::word_t     mem_alu_y,
  input  core_pkg::reg_addr_t wb_rd,
  input  logic                wb_reg_we,
  input  core_pkg::word_t     wb_value,
  output logic                load_use_stall,
  output core_pkg::reg_addr_t ex_rd,
  output core_pkg::word_t     ex_alu_y,
  output core_pkg::word_t     ex_store_data,
  output logic                ex_reg_we,
  output logic                ex_load,
  output logic                ex_store
);
  import core_pkg::*;

  reg_addr_t id_ex_rs1;
  reg_addr_t id_ex_rs2;
  word_t     id_ex_rs1_data;
  word_t     id_ex_rs2_data;
  word_t     id_ex_imm;
  alu_op_t   id_ex_alu_op;
  logic      id_ex_use_imm;
  forward_t  fwd_a;
  forward_t  fwd_b;
  word_t     operand_a;
  word_t     operand_b;
  word_t     rs2_value;

  // Load in ID/EX whose result the IF/ID instruction reads
  assign load_use_stall = ex_load && ex_rd != '0 &&
                          (ex_rd == rs1_addr || ex_rd == rs2_addr);

  // A stall turns the ID/EX control into a bubble
  always_ff @(posedge clock) begin
    if (reset) begin
      ex_reg_we <= 1'b0;
      ex_load <= 1'b0;
      ex_store <= 1'b0;
      id_ex_rs1 <= '0;
      id_ex_rs2 <= '0;
    end else if (!mem_busy) begin
      ex_reg_we <= id_reg_we && !load_use_stall;
      ex_load <= id_load && !load_use_stall;
      ex_store <= id_store && !load_use_stall;
      id_ex_rs1 <= load_use_stall ? '0 : rs1_addr;
      id_ex_rs2 <= load_use_stall ? '0 : rs2_addr;
    end
  end

  always_ff @(posedge clock) begin
    if (!mem_busy) begin
      ex_rd <= id_rd;
      id_ex_rs1_data <= rs1_data;
      id_ex_rs2_data <= rs2_data;
      id_ex_imm <= id_imm;
      id_ex_alu_op <= id_alu_op;
      id_ex_use_imm <= id_use_imm;
    end
  end

  // Youngest producer wins
  function automatic forward_t pick_source(input reg_addr_t rs);
    forward_t sel;
    if (mem_reg_we && mem_rd == rs) begin
      sel = FwdMem;
    end else if (wb_reg_we && wb_rd == rs) begin
      sel = FwdWb;
    end else begin
      sel = FwdNone;
    end
    return sel;
  endfunction

  function automatic word_t forward_value(input forward_t sel, input word_t reg_value);
    word_t value;
    case (sel)
      FwdMem:  value = mem_alu_y;
      FwdWb:   value = wb_value;
      default: value = reg_value;
    endcase
    return value;
  endfunction

  always_comb begin
    fwd_a = pick_source(id_ex_rs1);
    fwd_b = pick_source(id_ex_rs2);
    operand_a = forward_value(fwd_a, id_ex_rs1_data);
    rs2_value = forward_value(fwd_b, id_ex_rs2_data);
    operand_b = id_ex_use_imm ? id_ex_imm : rs2_value;
  end

  assign ex_store_data = rs2_value;

  always_comb begin
    case (id_ex_alu_op)
      AluAdd:   ex_alu_y = operand_a + operand_b;
      AluSub:   ex_alu_y = operand_a - operand_b;
      AluAnd:   ex_alu_y = operand_a & operand_b;
      AluOr:    ex_alu_y = operand_a | operand_b;
      AluXor:   ex_alu_y = operand_a ^ operand_b;
      AluSlt:   ex_alu_y = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      AluSltu:  ex_alu_y = {{(xlen-1){1'b0}}, operand_a < operand_b};
      AluSll:   ex_alu_y = operand_a << operand_b[4:0];
      AluSrl:   ex_alu_y = operand_a >> operand_b[4:0];
      AluSra:   ex_alu_y = $signed(operand_a) >>> operand_b[4:0];
      AluPassB: ex_alu_y = operand_b;
      default:  ex_alu_y = '0;
    endcase
  end

  // The stall keeps a load result from ever being taken out of EX/MEM
  a_no_mem_fwd_of_load: assert property (
    @(posedge clock) disable iff (reset)
      (ex_load && ex_rd != '0 && !mem_busy) |=> (fwd_a != FwdMem && fwd_b != FwdMem)
  );

endmodule

//--- source/memory_writeback.sv
`timescale 1ns/1ps

module memory_writeback (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t ex_rd,
  input  core_pkg::word_t     ex_alu_y,
  input  core_pkg::word_t     ex_store_data,
  input  logic                ex_reg_we,
  input  logic                ex_load,
  input  logic                ex_store,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output core_pkg::word_t     wb_adr,
  output core_pkg::word_t     wb_dat_w,
  input  core_pkg::word_t     wb_dat_r,
  input  logic                wb_ack,
  output logic                mem_busy,
  output core_pkg::reg_addr_t mem_rd,
  output logic                mem_reg_we,
  output core_pkg::word_t     mem_alu_y,
  output core_pkg::reg_addr_t wb_rd,
  output logic                wb_reg_we,
  output core_pkg::word_t     wb_value
);
  import core_pkg::*;

  logic  mem_load;
  logic  mem_store;
  word_t mem_store_data;
  logic  wb_load;
  word_t wb_alu_y;
  word_t wb_load_data;

  // EX/MEM
  always_ff @(posedge clock) begin
    if (reset) begin
      mem_reg_we <= 1'b0;
      mem_load <= 1'b0;
      mem_store <= 1'b0;
    end else if (!mem_busy) begin
      mem_reg_we <= ex_reg_we;
      mem_load <= ex_load;
      mem_store <= ex_store;
    end
  end

  always_ff @(posedge clock) begin
    if (!mem_busy) begin
      mem_rd <= ex_rd;
      mem_alu_y <= ex_alu_y;
      mem_store_data <= ex_store_data;
    end
  end

  // One word per Wishbone classic transfer
  assign wb_cyc   = mem_load || mem_store;
  assign wb_stb   = wb_cyc;
  assign wb_we    = mem_store;
  assign wb_adr   = mem_alu_y;
  assign wb_dat_w = mem_store_data;
  assign mem_busy = wb_cyc && !wb_ack;

  // MEM/WB
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_reg_we <= 1'b0;
      wb_load <= 1'b0;
    end else if (!mem_busy) begin
      wb_reg_we <= mem_reg_we;
      wb_load <= mem_load;
    end
  end

  always_ff @(posedge clock) begin
    if (!mem_busy) begin
      wb_rd <= mem_rd;
      wb_alu_y <= mem_alu_y;
    end
    if (mem_load && wb_ack) begin
      wb_load_data <= wb_dat_r;
    end
  end

  assign wb_value = wb_load ? wb_load_data : wb_alu_y;

  // A request waits unchanged until the slave acknowledges it
  a_request_held: assert property (
    @(posedge clock) disable iff (reset)
      (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable(wb_adr) &&
                               $stable(wb_we) && $stable(wb_dat_w))
  );

endmodule

//--- source/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core (
  input  logic            clock,
  input  logic            reset,
  output core_pkg::word_t inst_addr,
  input  core_pkg::word_t inst,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output core_pkg::word_t wb_adr,
  output core_pkg::word_t wb_dat_w,
  input  core_pkg::word_t wb_dat_r,
  input  logic            wb_ack
);
  import core_pkg::*;

  logic      mem_busy;
  logic      load_use_stall;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t id_rd;
  word_t     id_imm;
  alu_op_t   id_alu_op;
  logic      id_use_imm;
  logic      id_reg_we;
  logic      id_load;
  logic      id_store;
  reg_addr_t ex_rd;
  word_t     ex_alu_y;
  word_t     ex_store_data;
  logic      ex_reg_we;
  logic      ex_load;
  logic      ex_store;
  reg_addr_t mem_rd;
  logic      mem_reg_we;
  word_t     mem_alu_y;
  reg_addr_t wb_rd;
  logic      wb_reg_we;
  word_t     wb_value;

  fetch_decode u_fetch_decode (
    .clock          (clock),
    .reset          (reset),
    .inst_addr      (inst_addr),
    .inst           (inst),
    .mem_busy       (mem_busy),
    .load_use_stall (load_use_stall),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .id_rd          (id_rd),
    .id_imm         (id_imm),
    .id_alu_op      (id_alu_op),
    .id_use_imm     (id_use_imm),
    .id_reg_we      (id_reg_we),
    .id_load        (id_load),
    .id_store       (id_store)
  );

  register_file u_register_file (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_reg_we),
    .wr_addr  (wb_rd),
    .wr_data  (wb_value)
  );

  execute_stage u_execute_stage (
    .clock          (clock),
    .reset          (reset),
    .mem_busy       (mem_busy),
    .id_rd          (id_rd),
    .id_imm         (id_imm),
    .id_alu_op      (id_alu_op),
    .id_use_imm     (id_use_imm),
    .id_reg_we      (id_reg_we),
    .id_load        (id_load),
    .id_store       (id_store),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .mem_rd         (mem_rd),
    .mem_reg_we     (mem_reg_we),
    .mem_alu_y      (mem_alu_y),
    .wb_rd          (wb_rd),
    .wb_reg_we      (wb_reg_we),
    .wb_value       (wb_value),
    .load_use_stall (load_use_stall),
    .ex_rd          (ex_rd),
    .ex_alu_y       (ex_alu_y),
    .ex_store_data  (ex_store_data),
    .ex_reg_we      (ex_reg_we),
    .ex_load        (ex_load),
    .ex_store       (ex_store)
  );

  memory_writeback u_memory_writeback (
    .clock         (clock),
    .reset         (reset),
    .ex_rd         (ex_rd),
    .ex_alu_y      (ex_alu_y),
    .ex_store_data (ex_store_data),
    .ex_reg_we     (ex_reg_we),
    .ex_load       (ex_load),
    .ex_store      (ex_store),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .mem_busy      (mem_busy),
    .mem_rd        (mem_rd),
    .mem_reg_we    (mem_reg_we),
    .mem_alu_y     (mem_alu_y),
    .wb_rd         (wb_rd),
    .wb_reg_we     (wb_reg_we),
    .wb_value      (wb_value)
  );

endmodule

//--- bench/bench_memory.sv
`timescale 1ns/1ps

module bench_memory (
  input  logic            clock,
  input  logic            reset,
  input  logic            waits_enabled,
  input  core_pkg::word_t program_words [64],
  input  core_pkg::word_t program_length,
  input  core_pkg::word_t inst_addr,
  output core_pkg::word_t inst,
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  core_pkg::word_t wb_adr,
  input  core_pkg::word_t wb_dat_w,
  output core_pkg::word_t wb_dat_r,
  output logic            wb_ack
);
  import core_pkg::*;

  word_t      data_mem [256];
  logic [1:0] waits_left = 2'd0;
  logic       held_reset = 1'b1;
  logic       held_waits = 1'b0;
  logic       held_stb = 1'b0;
  logic       held_fire = 1'b0;
  logic       held_we = 1'b0;
  word_t      held_adr = '0;
  word_t      held_dat = '0;

  function automatic word_t fill_word(input int index);
    return word_t'(index) * 32'h9e37_79b1 ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [1:0] pick_waits(input logic enabled);
    word_t r;
    r = $urandom;
    return enabled ? r[1:0] : 2'd0;
  endfunction

  // Past the end of the program the ROM returns NOPs
  assign inst = ((inst_addr >> 2) < program_length) ? program_words[inst_addr[7:2]]
                                                     : nop_instruction;

  assign wb_dat_r = data_mem[wb_adr[9:2]];
  assign wb_ack   = wb_cyc && wb_stb && waits_left == 2'd0;

  // Sampled mid-cycle and acted on just after the next rising edge
  always @(negedge clock) begin
    held_reset = reset;
    held_waits = waits_enabled;
    held_stb = wb_stb;
    held_fire = wb_stb && wb_ack;
    held_we = wb_we;
    held_adr = wb_adr;
    held_dat = wb_dat_w;
  end

  always @(posedge clock) begin
    #2;
    if (held_reset) begin
      for (int i = 0; i < 256; i++) begin
        data_mem[i] = fill_word(i);
      end
      waits_left = pick_waits(held_waits);
    end else if (held_fire) begin
      if (held_we) begin
        data_mem[held_adr[9:2]] = held_dat;
      end
      waits_left = pick_waits(held_waits);
    end else if (held_stb) begin
      waits_left = waits_left - 2'd1;
    end
  end

endmodule

//--- bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  logic  clock;
  logic  reset;
  logic  waits_enabled;
  word_t inst_addr;
  word_t inst;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  word_t wb_adr;
  word_t wb_dat_w;
  word_t wb_dat_r;
  logic  wb_ack;

  word_t program_words [64];
  word_t program_length;
  word_t ref_regs [32];
  word_t ref_mem [256];
  word_t exp_adr [$];
  logic  exp_we [$];
  word_t exp_dat [$];
  word_t obs_adr [$];
  logic  obs_we [$];
  word_t obs_dat [$];

  logic  pending;
  logic  held_we;
  word_t held_adr;
  word_t held_dat;
  int    errors;
  int    tests_run;
  int    tests_failed;
  int    cycle_budget;
  int    cycle_count = 0;

  pipeline_core u_pipeline_core (
    .clock    (clock),
    .reset    (reset),
    .inst_addr(inst_addr),
    .inst     (inst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  bench_memory u_bench_memory (
    .clock         (clock),
    .reset         (reset),
    .waits_enabled (waits_enabled),
    .program_words (program_words),
    .program_length(program_length),
    .inst_addr     (inst_addr),
    .inst          (inst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_budget) begin
      $display("Watchdog expired after %0d cycles, the core stopped making progress",
               cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic check_bus(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, expected);
    end
  endtask

  // Reference results by RV32I rules
  function automatic word_t rv_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                   input word_t b);
    word_t y;
    case (f3)
      3'b000:  y = alt ? a - b : a + b;
      3'b001:  y = a << b[4:0];
      3'b010:  y = {31'b0, $signed(a) < $signed(b)};
      3'b011:  y = {31'b0, a < b};
      3'b100:  y = a ^ b;
      3'b101:  y = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  task automatic emit(input word_t word);
    if (program_length >= 64) begin
      errors++;
      $display("Program does not fit into the 64-word instruction ROM");
    end else begin
      program_words[program_length[5:0]] = word;
      program_length = program_length + 1;
    end
  endtask

  task automatic do_reg(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                        input reg_addr_t rs1, input reg_addr_t rs2);
    emit({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OpReg});
    if (rd != '0) begin
      ref_regs[rd] = rv_alu(f3, alt, ref_regs[rs1], ref_regs[rs2]);
    end
  endtask

  task automatic do_imm(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                        input logic [11:0] imm);
    emit({imm, rs1, f3, rd, OpImm});
    if (rd != '0) begin
      ref_regs[rd] = rv_alu(f3, f3 == 3'b101 && imm[10], ref_regs[rs1],
                            {{20{imm[11]}}, imm});
    end
  endtask

  task automatic do_lui(input reg_addr_t rd, input logic [19:0] imm);
    emit({imm, rd, OpLui});
    if (rd != '0) begin
      ref_regs[rd] = {imm, 12'b0};
    end
  endtask

  // Loads and stores use x0 as base
  task automatic do_store(input reg_addr_t rs2, input logic [11:0] offset);
    word_t addr;
    addr = {{20{offset[11]}}, offset};
    emit({offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], OpStore});
    ref_mem[addr[9:2]] = ref_regs[rs2];
    exp_adr.push_back(addr);
    exp_we.push_back(1'b1);
    exp_dat.push_back(ref_regs[rs2]);
  endtask

  task automatic do_load(input reg_addr_t rd, input logic [11:0] offset);
    word_t addr;
    addr = {{20{offset[11]}}, offset};
    emit({offset, 5'd0, 3'b010, rd, OpLoad});
    if (rd != '0) begin
      ref_regs[rd] = ref_mem[addr[9:2]];
    end
    exp_adr.push_back(addr);
    exp_we.push_back(1'b0);
    exp_dat.push_back('0);
  endtask

  task automatic load_constant(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h0000_0800;
    do_lui(rd, upper[31:12]);
    do_imm(3'b000, rd, rd, value[11:0]);
  endtask

  // Reset stays high for 15 cycles here and one more in release_reset
  task automatic start_program(input logic waits);
    @(posedge clock);
    #2;
    reset = 1'b1;
    waits_enabled = waits;
    program_length = '0;
    for (int i = 0; i < 64; i++) begin
      program_words[i] = nop_instruction;
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    exp_adr.delete();
    exp_we.delete();
    exp_dat.delete();
    obs_adr.delete();
    obs_we.delete();
    obs_dat.delete();
    repeat (15) @(posedge clock);
    #2;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = u_bench_memory.data_mem[i];
    end
  endtask

  task automatic release_reset();
    cycle_budget = cycle_budget + int'(program_length) * 8;
    @(posedge clock);
    #2;
    reset = 1'b0;
  endtask

  task automatic observe_cycle();
    @(negedge clock);
    if (pending) begin
      check_bus("wb_stb", wb_stb, 1'b1);
      check_word("wb_adr", wb_adr, held_adr);
      check_bus("wb_we", wb_we, held_we);
      check_word("wb_dat_w", wb_dat_w, held_dat);
    end
    if (wb_stb) begin
      check_bus("wb_cyc", wb_cyc, 1'b1);
    end
    if (wb_stb && wb_ack) begin
      obs_adr.push_back(wb_adr);
      obs_we.push_back(wb_we);
      obs_dat.push_back(wb_dat_w);
    end
    pending = wb_stb && !wb_ack;
    held_adr = wb_adr;
    held_we = wb_we;
    held_dat = wb_dat_w;
  endtask

  task automatic run_and_compare();
    release_reset();
    pending = 1'b0;
    do begin
      observe_cycle();
    end while (obs_adr.size() < exp_adr.size());
    // A few more cycles to catch stray transfers
    repeat (4) observe_cycle();
    check_word("transfer count", obs_adr.size(), exp_adr.size());
    for (int i = 0; i < obs_adr.size() && i < exp_adr.size(); i++) begin
      check_word("wb_adr", obs_adr[i], exp_adr[i]);
      check_bus("wb_we", obs_we[i], exp_we[i]);
      if (exp_we[i]) begin
        check_word("wb_dat_w", obs_dat[i], exp_dat[i]);
      end
    end
    for (int i = 0; i < 256; i++) begin
      check_word($sformatf("data_mem[%0d]", i), u_bench_memory.data_mem[i], ref_mem[i]);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%-30s passed", name);
    end else begin
      tests_failed++;
      $display("%-30s failed", name);
    end
  endtask

  task automatic test_reset_fetch();
    int errors_before;
    errors_before = errors;
    start_program(1'b0);
    release_reset();
    @(negedge clock);
    check_word("inst_addr", inst_addr, reset_pc);
    check_bus("wb_cyc", wb_cyc, 1'b0);
    check_bus("wb_stb", wb_stb, 1'b0);
    for (int k = 1; k <= 8; k++) begin
      @(negedge clock);
      check_word("inst_addr", inst_addr, reset_pc + word_t'(4 * k));
      check_bus("wb_stb", wb_stb, 1'b0);
    end
    report_test("reset and sequential fetch", errors_before);
  endtask

  // {alt, funct3} of the register forms
  function automatic logic [3:0] reg_op(input int k);
    case (k)
      0:       return 4'b0_000;
      1:       return 4'b1_000;
      2:       return 4'b0_001;
      3:       return 4'b0_010;
      4:       return 4'b0_011;
      5:       return 4'b0_100;
      6:       return 4'b0_101;
      7:       return 4'b1_101;
      8:       return 4'b0_110;
      default: return 4'b0_111;
    endcase
  endfunction

  task automatic test_alu_ops(input logic waits);
    word_t       r;
    logic [3:0]  op;
    logic [11:0] imm;
    int          errors_before;
    errors_before = errors;
    start_program(waits);
    r = $urandom;
    load_constant(5'd1, r);
    r = $urandom;
    load_constant(5'd2, r);
    for (int k = 0; k < 10; k++) begin
      op = reg_op(k);
      do_reg(op[2:0], op[3], 5'd3, 5'd1, 5'd2);
      do_store(5'd3, 12'(4 * k));
    end
    // SUB has no immediate form
    for (int k = 0; k < 10; k++) begin
      op = reg_op(k);
      if (k != 1) begin
        r = $urandom;
        imm = r[11:0];
        if (op[2:0] == 3'b001 || op[2:0] == 3'b101) begin
          imm = {1'b0, op[3], 5'b0, r[4:0]};
        end
        do_imm(op[2:0], 5'd4, 5'd1, imm);
        do_store(5'd4, 12'(64 + 4 * k));
      end
    end
    r = $urandom;
    do_lui(5'd5, r[19:0]);
    do_store(5'd5, 12'd128);
    run_and_compare();
    report_test(waits ? "ALU ops with wait states" : "ALU ops", errors_before);
  endtask

  task automatic test_dependent_chains(input logic waits);
    word_t     r;
    reg_addr_t rd;
    reg_addr_t other;
    int        errors_before;
    errors_before = errors;
    start_program(waits);
    for (int j = 0; j < 3; j++) begin
      r = $urandom;
      load_constant(reg_addr_t'(10 + j), r);
    end
    // Each instruction reads its own result from d back and the previous one
    for (int d = 1; d <= 3; d++) begin
      for (int k = 0; k < 8; k++) begin
        rd = reg_addr_t'(10 + k % d);
        other = reg_addr_t'(10 + (k + d - 1) % d);
        r = $urandom;
        case (k % 4)
          0:       do_reg(3'b000, 1'b0, rd, rd, other);
          1:       do_imm(3'b100, rd, rd, r[11:0]);
          2:       do_reg(3'b000, 1'b1, rd, other, rd);
          default: do_imm(3'b000, rd, rd, r[11:0]);
        endcase
      end
      for (int j = 0; j < 3; j++) begin
        do_store(reg_addr_t'(10 + j), 12'(256 + 12 * (d - 1) + 4 * j));
      end
    end
    run_and_compare();
    report_test(waits ? "dependent chains with wait states" : "dependent chains",
                errors_before);
  endtask

  task automatic test_load_use(input logic waits);
    word_t r;
    int    errors_before;
    errors_before = errors;
    start_program(waits);
    r = $urandom;
    load_constant(5'd6, r);
    do_store(5'd6, 12'h200);
    do_load(5'd7, 12'h200);
    do_reg(3'b000, 1'b0, 5'd8, 5'd7, 5'd7);
    do_store(5'd8, 12'h204);
    do_load(5'd9, 12'h204);
    do_store(5'd9, 12'h208);
    do_load(5'd13, 12'h204);
    do_reg(3'b000, 1'b1, 5'd15, 5'd6, 5'd13);
    do_store(5'd15, 12'h20c);
    do_load(5'd14, 12'h208);
    do_imm(3'b000, 5'd14, 5'd14, 12'h001);
    do_store(5'd14, 12'h210);
    run_and_compare();
    report_test(waits ? "load-use stall with wait states" : "load-use stall", errors_before);
  endtask

  initial begin
    void'($urandom(32'h73f8));
    clock = 1'b0;
    reset = 1'b1;
    waits_enabled = 1'b0;
    program_length = '0;
    for (int i = 0; i < 64; i++) begin
      program_words[i] = nop_instruction;
    end
    pending = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_budget = 200;

    test_reset_fetch();
    test_alu_ops(1'b0);
    test_dependent_chains(1'b0);
    test_load_use(1'b0);
    test_alu_ops(1'b1);
    test_dependent_chains(1'b1);
    test_load_use(1'b1);

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- all.f
source/core_pkg.sv
source/register_file.sv
source/fetch_decode.sv
source/execute_stage.sv
source/memory_writeback.sv
source/pipeline_core.sv
bench/bench_memory.sv
bench/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_tb -f all.f -o core_tb_sim

./obj_dir/core_tb_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
